//--- rtl/fcmp_macros.svh
// Binary64 field widths and the canonical quiet NaN for the compare unit
`ifndef FCMP_MACROS_SVH
`define FCMP_MACROS_SVH

// Whole operand word
`define FCMP_DATA_W 64

// Biased exponent field
`define FCMP_EXP_W 11

// Stored fraction field, hidden bit not included
`define FCMP_FRAC_W 52

// Sign 0, exponent all ones, fraction MSB set
`define FCMP_QNAN 64'h7FF8_0000_0000_0000

`endif

//--- rtl/fcmp_pkg.sv
// Opcode and handshake FSM types shared by the compare and min/max unit
`default_nettype none

package fcmp_pkg;

  // --------------------
  // Opcodes
  // --------------------
  // Ordered forms are false when any operand is NaN
  // The U forms are true when any operand is NaN
  typedef enum logic [3:0] {
    FEQ   = 4'd0,
    FNE   = 4'd1,
    FLT   = 4'd2,
    FLE   = 4'd3,
    FUEQ  = 4'd4,
    FUNE  = 4'd5,
    FULT  = 4'd6,
    FULE  = 4'd7,
    FORD  = 4'd8,
    FUORD = 4'd9,
    FMAX  = 4'd10,
    FMIN  = 4'd11
  } fcmp_op_e;

  // --------------------
  // Handshake FSM
  // --------------------
  typedef enum logic [1:0] {
    // Waiting for req
    IDLE = 2'd0,
    // Operands held, result loads on the next edge
    CALC = 2'd1,
    // ack high until req falls
    ACK  = 2'd2,
    // req seen low, ack clears on the next edge
    DROP = 2'd3
  } fcmp_state_e;

endpackage

`default_nettype wire

//--- rtl/fcmp_classify.sv
// Operand classifier that splits both binary64 words into fields and flags NaNs and zeros
`default_nettype none
`include "fcmp_macros.svh"

module fcmp_classify (
  input  wire  [`FCMP_DATA_W-1:0] src0,
  input  wire  [`FCMP_DATA_W-1:0] src1,
  output logic                    src0_s,
  output logic [`FCMP_EXP_W-1:0]  src0_e,
  output logic [`FCMP_FRAC_W-1:0] src0_f,
  output logic                    src1_s,
  output logic [`FCMP_EXP_W-1:0]  src1_e,
  output logic [`FCMP_FRAC_W-1:0] src1_f,
  output logic                    src0_snan,
  output logic                    src0_qnan,
  output logic                    src1_snan,
  output logic                    src1_qnan,
  output logic                    src0_zero,
  output logic                    src1_zero
);

  logic src0_e_ones;
  logic src1_e_ones;
  logic src0_f_nz;
  logic src1_f_nz;

  // --------------------
  // Field split
  // --------------------
  assign src0_s = src0[`FCMP_DATA_W-1];
  assign src0_e = src0[`FCMP_DATA_W-2 -: `FCMP_EXP_W];
  assign src0_f = src0[`FCMP_FRAC_W-1:0];

  assign src1_s = src1[`FCMP_DATA_W-1];
  assign src1_e = src1[`FCMP_DATA_W-2 -: `FCMP_EXP_W];
  assign src1_f = src1[`FCMP_FRAC_W-1:0];

  // --------------------
  // Classes
  // --------------------
  assign src0_e_ones = &src0_e;
  assign src1_e_ones = &src1_e;
  assign src0_f_nz   = |src0_f;
  assign src1_f_nz   = |src1_f;

  // Fraction MSB decides quiet vs signaling
  assign src0_qnan = src0_e_ones & src0_f[`FCMP_FRAC_W-1];
  assign src0_snan = src0_e_ones & src0_f_nz & ~src0_f[`FCMP_FRAC_W-1];
  assign src1_qnan = src1_e_ones & src1_f[`FCMP_FRAC_W-1];
  assign src1_snan = src1_e_ones & src1_f_nz & ~src1_f[`FCMP_FRAC_W-1];

  // Subnormals count as ordinary nonzero numbers
  assign src0_zero = ~(|src0_e) & ~src0_f_nz;
  assign src1_zero = ~(|src1_e) & ~src1_f_nz;

endmodule

`default_nettype wire

//--- rtl/fcmp_mag_cmp.sv
// Magnitude comparator that orders the operands and derives equality and value-order facts
`default_nettype none
`include "fcmp_macros.svh"

module fcmp_mag_cmp (
  input  wire                     src0_s,
  input  wire  [`FCMP_EXP_W-1:0]  src0_e,
  input  wire  [`FCMP_FRAC_W-1:0] src0_f,
  input  wire                     src0_zero,
  input  wire                     src1_s,
  input  wire  [`FCMP_EXP_W-1:0]  src1_e,
  input  wire  [`FCMP_FRAC_W-1:0] src1_f,
  input  wire                     src1_zero,
  output logic                    src_a_s,
  output logic [`FCMP_EXP_W-1:0]  src_a_e,
  output logic [`FCMP_FRAC_W-1:0] src_a_f,
  output logic                    src_b_s,
  output logic [`FCMP_EXP_W-1:0]  src_b_e,
  output logic [`FCMP_FRAC_W-1:0] src_b_f,
  output logic                    src_chg,
  output logic                    src0_eq_src1,
  output logic                    act_s,
  output logic                    both_zero
);

  logic exp_lt;
  logic exp_eq;
  logic frac_lt;
  logic frac_eq;
  logic mag_lt;
  logic mag_eq;

  // --------------------
  // Magnitude compare
  // --------------------
  assign exp_lt  = src0_e < src1_e;
  assign exp_eq  = src0_e == src1_e;
  assign frac_lt = src0_f < src1_f;
  assign frac_eq = src0_f == src1_f;

  // |src0| < |src1|, exponent first then fraction
  assign mag_lt = exp_lt | (exp_eq & frac_lt);
  assign mag_eq = exp_eq & frac_eq;

  assign src0_eq_src1 = mag_eq;
  assign both_zero    = src0_zero & src1_zero;

  // --------------------
  // Ordering
  // --------------------
  // Swap only when src1 is strictly larger, so src_a is never the smaller one
  assign src_chg = mag_lt;

  assign src_a_s = src_chg ? src1_s : src0_s;
  assign src_a_e = src_chg ? src1_e : src0_e;
  assign src_a_f = src_chg ? src1_f : src0_f;
  assign src_b_s = src_chg ? src0_s : src1_s;
  assign src_b_e = src_chg ? src0_e : src1_e;
  assign src_b_f = src_chg ? src0_f : src1_f;

  // Signed value order, src0 strictly below src1
  always_comb begin
    case ({src0_s, src1_s})
      2'b10:   act_s = ~both_zero;
      2'b01:   act_s = 1'b0;
      2'b00:   act_s = mag_lt;
      default: act_s = ~mag_lt & ~mag_eq; // both negative, larger magnitude is smaller
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/fcmp_cmp_max.sv
// Compare and max/min selector that turns magnitude facts into a predicate and selected fields
`default_nettype none
`include "fcmp_macros.svh"

module fcmp_cmp_max import fcmp_pkg::*; (
  input  wire  fcmp_op_e          op,
  input  wire                     act_s,
  input  wire                     both_zero,
  input  wire                     src0_eq_src1,
  input  wire                     src_chg,
  input  wire                     src_a_s,
  input  wire  [`FCMP_EXP_W-1:0]  src_a_e,
  input  wire  [`FCMP_FRAC_W-1:0] src_a_f,
  input  wire                     src_b_s,
  input  wire  [`FCMP_EXP_W-1:0]  src_b_e,
  input  wire  [`FCMP_FRAC_W-1:0] src_b_f,
  input  wire                     src0_snan,
  input  wire                     src0_qnan,
  input  wire                     src1_snan,
  input  wire                     src1_qnan,
  output logic                    cmp_r,
  output logic                    sel_s,
  output logic [`FCMP_EXP_W-1:0]  sel_e,
  output logic [`FCMP_FRAC_W-1:0] sel_f
);

  logic any_nan;
  logic val_eq;
  logic cmp_eq;
  logic cmp_ne;
  logic cmp_lt;
  logic cmp_le;
  logic op_max;
  logic pick_b_max;
  logic pick_b_min;
  logic both0_s;

  // --------------------
  // Compare predicates
  // --------------------
  assign any_nan = src0_snan | src0_qnan | src1_snan | src1_qnan;

  // Equal magnitude with matching sign, or +0 against -0
  assign val_eq = (src_a_s == src_b_s) & src0_eq_src1 | both_zero;

  assign cmp_eq = val_eq & ~any_nan;
  assign cmp_ne = ~val_eq & ~any_nan;
  assign cmp_lt = act_s & ~val_eq & ~any_nan;
  assign cmp_le = cmp_eq | cmp_lt;

  always_comb begin
    case (op)
      FEQ:     cmp_r = cmp_eq;
      FNE:     cmp_r = cmp_ne;
      FLT:     cmp_r = cmp_lt;
      FLE:     cmp_r = cmp_le;
      FUEQ:    cmp_r = cmp_eq | any_nan;
      FUNE:    cmp_r = cmp_ne | any_nan;
      FULT:    cmp_r = cmp_lt | any_nan;
      FULE:    cmp_r = cmp_le | any_nan;
      FORD:    cmp_r = ~any_nan;
      FUORD:   cmp_r = any_nan;
      default: cmp_r = 1'b0;
    endcase
  end

  // --------------------
  // Max/min select
  // --------------------
  // src_b holds src0 only after a swap, hence the XOR with src_chg
  assign op_max     = (op == FMAX);
  assign pick_b_max = act_s ^ src_chg;
  assign pick_b_min = ~act_s ^ src_chg;

  // max(+0,-0) is +0 and min(+0,-0) is -0
  assign both0_s = op_max ? (src_a_s & src_b_s) : (src_a_s | src_b_s);

  assign sel_s = both_zero ? both0_s :
                 op_max    ? (pick_b_max ? src_b_s : src_a_s)
                           : (pick_b_min ? src_b_s : src_a_s);

  assign sel_e = op_max ? (pick_b_max ? src_b_e : src_a_e)
                        : (pick_b_min ? src_b_e : src_a_e);

  assign sel_f = op_max ? (pick_b_max ? src_b_f : src_a_f)
                        : (pick_b_min ? src_b_f : src_a_f);

  // Opcode arrives from outside through the operand register
  always_comb begin
    assert (op inside {FEQ, FNE, FLT, FLE, FUEQ, FUNE, FULT, FULE,
                       FORD, FUORD, FMAX, FMIN})
      else $error("fcmp_cmp_max: undefined opcode %0d", op);
  end

endmodule

`default_nettype wire

//--- rtl/fcmp_result_stage.sv
// Handshake and result stage that captures operands, applies NaN rules and holds the result
`default_nettype none
`include "fcmp_macros.svh"

module fcmp_result_stage import fcmp_pkg::*; (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req,
  input  wire  fcmp_op_e          op,
  input  wire  [`FCMP_DATA_W-1:0] src0,
  input  wire  [`FCMP_DATA_W-1:0] src1,
  input  wire                     cmp_r,
  input  wire                     sel_s,
  input  wire  [`FCMP_EXP_W-1:0]  sel_e,
  input  wire  [`FCMP_FRAC_W-1:0] sel_f,
  input  wire                     src0_snan,
  input  wire                     src0_qnan,
  input  wire                     src1_snan,
  input  wire                     src1_qnan,
  output logic                    ack,
  output logic [`FCMP_DATA_W-1:0] result,
  output logic                    nv,
  output fcmp_op_e                op_q,
  output logic [`FCMP_DATA_W-1:0] src0_q,
  output logic [`FCMP_DATA_W-1:0] src1_q
);

  fcmp_state_e             state;
  fcmp_state_e             state_nxt;
  logic                    src0_nan;
  logic                    src1_nan;
  logic                    nv_nxt;
  logic [`FCMP_DATA_W-1:0] result_nxt;

  // --------------------
  // Handshake FSM
  // --------------------
  always_comb begin
    case (state)
      IDLE:    state_nxt = req ? CALC : IDLE;
      CALC:    state_nxt = ACK;
      ACK:     state_nxt = req ? ACK : DROP;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      ack    <= 1'b0;
      op_q   <= FEQ;
      result <= '0;
      nv     <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == IDLE && req) begin
        op_q <= op;
      end
      if (state == CALC) begin
        ack    <= 1'b1;
        result <= result_nxt;
        nv     <= nv_nxt;
      end else if (state == DROP) begin
        ack <= 1'b0;
      end
    end
  end

  // Operand words
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      src0_q <= src0;
      src1_q <= src1;
    end
  end

  // --------------------
  // Result and flag
  // --------------------
  assign src0_nan = src0_snan | src0_qnan;
  assign src1_nan = src1_snan | src1_qnan;

  // Signaling compares raise nv on a quiet NaN too
  assign nv_nxt = src0_snan | src1_snan | ((op_q == FLT || op_q == FLE) & (src0_nan | src1_nan));

  always_comb begin
    if (op_q == FMAX || op_q == FMIN) begin
      if (src0_nan && src1_nan) begin
        result_nxt = `FCMP_QNAN;
      end else if (src0_nan) begin
        result_nxt = src1_q;
      end else if (src1_nan) begin
        result_nxt = src0_q;
      end else begin
        result_nxt = {sel_s, sel_e, sel_f};
      end
    end else begin
      result_nxt = {{(`FCMP_DATA_W-1){1'b0}}, cmp_r};
    end
  end

  // ack follows a request that was still up on the previous edge
  a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else $error("fcmp_result_stage: ack rose without a request");

  // A new request only once the previous ack has cleared
  a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req) |-> !ack)
    else $error("fcmp_result_stage: req rose while ack was still high");

endmodule

`default_nettype wire

//--- rtl/fcmp_unit.sv
// Binary64 compare and min/max unit behind a four-phase req/ack handshake
`default_nettype none
`include "fcmp_macros.svh"

module fcmp_unit import fcmp_pkg::*; (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req,
  input  wire  fcmp_op_e          op,
  input  wire  [`FCMP_DATA_W-1:0] src0,
  input  wire  [`FCMP_DATA_W-1:0] src1,
  output logic                    ack,
  output logic [`FCMP_DATA_W-1:0] result,
  output logic                    nv
);

  // Registered request
  fcmp_op_e                op_q;
  logic [`FCMP_DATA_W-1:0] src0_q;
  logic [`FCMP_DATA_W-1:0] src1_q;

  // Classified fields
  logic                    src0_s;
  logic [`FCMP_EXP_W-1:0]  src0_e;
  logic [`FCMP_FRAC_W-1:0] src0_f;
  logic                    src1_s;
  logic [`FCMP_EXP_W-1:0]  src1_e;
  logic [`FCMP_FRAC_W-1:0] src1_f;
  logic                    src0_snan;
  logic                    src0_qnan;
  logic                    src1_snan;
  logic                    src1_qnan;
  logic                    src0_zero;
  logic                    src1_zero;

  // Ordered operands and magnitude facts
  logic                    src_a_s;
  logic [`FCMP_EXP_W-1:0]  src_a_e;
  logic [`FCMP_FRAC_W-1:0] src_a_f;
  logic                    src_b_s;
  logic [`FCMP_EXP_W-1:0]  src_b_e;
  logic [`FCMP_FRAC_W-1:0] src_b_f;
  logic                    src_chg;
  logic                    src0_eq_src1;
  logic                    act_s;
  logic                    both_zero;

  // Predicate and selected fields
  logic                    cmp_r;
  logic                    sel_s;
  logic [`FCMP_EXP_W-1:0]  sel_e;
  logic [`FCMP_FRAC_W-1:0] sel_f;

  fcmp_result_stage u_result_stage (
    .clk, .rst_n, .req, .op, .src0, .src1,
    .cmp_r, .sel_s, .sel_e, .sel_f,
    .src0_snan, .src0_qnan, .src1_snan, .src1_qnan,
    .ack, .result, .nv, .op_q, .src0_q, .src1_q
  );

  fcmp_classify u_classify (
    .src0 (src0_q),
    .src1 (src1_q),
    .src0_s, .src0_e, .src0_f, .src1_s, .src1_e, .src1_f,
    .src0_snan, .src0_qnan, .src1_snan, .src1_qnan,
    .src0_zero, .src1_zero
  );

  fcmp_mag_cmp u_mag_cmp (
    .src0_s, .src0_e, .src0_f, .src0_zero,
    .src1_s, .src1_e, .src1_f, .src1_zero,
    .src_a_s, .src_a_e, .src_a_f, .src_b_s, .src_b_e, .src_b_f,
    .src_chg, .src0_eq_src1, .act_s, .both_zero
  );

  fcmp_cmp_max u_cmp_max (
    .op (op_q),
    .act_s, .both_zero, .src0_eq_src1, .src_chg,
    .src_a_s, .src_a_e, .src_a_f, .src_b_s, .src_b_e, .src_b_f,
    .src0_snan, .src0_qnan, .src1_snan, .src1_qnan,
    .cmp_r, .sel_s, .sel_e, .sel_f
  );

endmodule

`default_nettype wire

//--- tb/fcmp_tb.sv
// Testbench for the binary64 compare and min/max unit with a reference model and result checker
`default_nettype none
`include "fcmp_macros.svh"

module fcmp_tb import fcmp_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RAND_ITER = 24;
  localparam int HOLD_OPS  = 3;
  localparam int N_NAN     = 6;
  localparam int N_NAN_OPS = 10;
  localparam int N_SPEC    = 6;
  localparam int NUM_OPS   = HOLD_OPS + RAND_ITER * 4 + N_NAN * N_NAN * N_NAN_OPS
                             + RAND_ITER * 4 + N_SPEC * N_SPEC * 2;
  // Eight cycles per operation plus room for reset and the hold cases
  localparam longint WATCHDOG_NS = longint'(NUM_OPS) * 8 * 100 + 10000;

  localparam logic [63:0] NAN_SET [N_NAN] = '{
    64'h7FF8_0000_0000_0000, 64'hFFF8_0000_0000_0001, 64'h7FF0_0000_0000_0001,
    64'h3FF0_0000_0000_0000, 64'hC000_0000_0000_0000, 64'h8000_0000_0000_0000
  };
  localparam fcmp_op_e NAN_OPS [N_NAN_OPS] = '{
    FEQ, FNE, FLT, FLE, FUEQ, FUNE, FULT, FULE, FORD, FUORD
  };
  // +0, -0, qNaN, negative sNaN, -3.0, +inf
  localparam logic [63:0] SPEC_SET [N_SPEC] = '{
    64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h7FF8_0000_0000_0000,
    64'hFFF4_0000_0000_0000, 64'hC008_0000_0000_0000, 64'h7FF0_0000_0000_0000
  };

  logic        clk;
  logic        rst_n;
  logic        req;
  fcmp_op_e    op;
  logic [63:0] src0;
  logic [63:0] src1;
  logic        ack;
  logic [63:0] result;
  logic        nv;

  integer      seed = 16;
  int          errors;
  int          checks;
  int          ops_run;
  logic [64:0] exp_q [$];

  fcmp_unit dut_i (
    .clk, .rst_n, .req, .op, .src0, .src1, .ack, .result, .nv
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Reference model
  // --------------------
  // Returns {nv, result}
  function automatic logic [64:0] expected_result(fcmp_op_e f_op, logic [63:0] a,
                                                  logic [63:0] b);
    logic        a_nan;
    logic        b_nan;
    logic        a_snan;
    logic        b_snan;
    logic        any_nan;
    logic        eq;
    logic        lt;
    logic        flag;
    logic [63:0] res;
    a_nan   = (a[62:52] == 11'h7FF) && (a[51:0] != '0);
    b_nan   = (b[62:52] == 11'h7FF) && (b[51:0] != '0);
    a_snan  = a_nan && !a[51];
    b_snan  = b_nan && !b[51];
    any_nan = a_nan || b_nan;
    // +0 and -0 are equal, otherwise equal values have equal bits
    eq = !any_nan && ((a[62:0] == '0 && b[62:0] == '0) || a == b);
    if (any_nan || eq) begin
      lt = 1'b0;
    end else if (a[63] != b[63]) begin
      lt = a[63];
    end else if (!a[63]) begin
      lt = a[62:0] < b[62:0];
    end else begin
      lt = a[62:0] > b[62:0];
    end
    res = '0;
    case (f_op)
      FEQ:   res[0] = eq;
      FNE:   res[0] = !any_nan && !eq;
      FLT:   res[0] = lt;
      FLE:   res[0] = lt || eq;
      FUEQ:  res[0] = eq || any_nan;
      FUNE:  res[0] = !eq;
      FULT:  res[0] = lt || any_nan;
      FULE:  res[0] = lt || eq || any_nan;
      FORD:  res[0] = !any_nan;
      FUORD: res[0] = any_nan;
      default: begin
        if (a_nan && b_nan) begin
          res = `FCMP_QNAN;
        end else if (a_nan) begin
          res = b;
        end else if (b_nan) begin
          res = a;
        end else if (eq && a[62:0] == '0) begin
          // Zero pair, max prefers +0 and min prefers -0
          if (f_op == FMAX) begin
            res = a[63] ? b : a;
          end else begin
            res = a[63] ? a : b;
          end
        end else if (f_op == FMAX) begin
          res = lt ? b : a;
        end else begin
          res = lt ? a : b;
        end
      end
    endcase
    flag = a_snan || b_snan || ((f_op == FLT || f_op == FLE) && any_nan);
    return {flag, res};
  endfunction

  // Random non-NaN operand
  function automatic logic [63:0] rand_operand();
    logic [63:0] v;
    v = {$random(seed), $random(seed)};
    if (&v[62:52]) begin
      v[62] = 1'b0;
    end
    return v;
  endfunction

  // --------------------
  // Stimulus
  // --------------------
  task automatic run_op(input fcmp_op_e t_op, input logic [63:0] a, input logic [63:0] b,
                        input int hold);
    int          edges;
    logic [63:0] held;
    logic        held_nv;
    @(negedge clk);
    exp_q.push_back(expected_result(t_op, a, b));
    ops_run++;
    op   = t_op;
    src0 = a;
    src1 = b;
    req  = 1'b1;
    edges = 0;
    while (!ack && edges < 8) begin
      @(negedge clk);
      edges++;
    end
    if (!ack) begin
      $display("Error at %0t ns: ack did not rise within 8 cycles of req", $time);
      errors++;
      void'(exp_q.pop_back());
    end else if (edges != 2) begin
      $display("Mismatch at %0t ns: ack edges after req expected 2, got %0d", $time, edges);
      errors++;
    end
    held    = result;
    held_nv = nv;
    // Back-pressure, ack, result and nv must hold
    repeat (hold) begin
      @(negedge clk);
      if (!ack) begin
        $display("Error at %0t ns: ack fell while req was still high", $time);
        errors++;
      end
      if (result !== held) begin
        $display("Mismatch at %0t ns: result during hold expected %h, got %h",
                 $time, held, result);
        errors++;
      end
      if (nv !== held_nv) begin
        $display("Mismatch at %0t ns: nv during hold expected %b, got %b",
                 $time, held_nv, nv);
        errors++;
      end
    end
    req = 1'b0;
    edges = 0;
    while (ack && edges < 8) begin
      @(negedge clk);
      edges++;
    end
    if (ack) begin
      $display("Error at %0t ns: ack stayed high after req fell", $time);
      errors++;
    end else if (edges != 2) begin
      $display("Mismatch at %0t ns: ack fall edges expected 2, got %0d", $time, edges);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    $display("Test %s done, %0d errors", name, errors - start_errors);
  endtask

  // --------------------
  // Result checker
  // --------------------
  initial begin : compare_proc
    logic [64:0] exp_v;
    forever begin
      @(posedge ack);
      @(negedge clk);
      if (exp_q.size() == 0) begin
        $display("Error at %0t ns: ack rose with no operation pending", $time);
        errors++;
      end else begin
        exp_v = exp_q.pop_front();
        checks++;
        if (result !== exp_v[63:0]) begin
          $display("Mismatch at %0t ns: result expected %h, got %h", $time, exp_v[63:0], result);
          errors++;
        end
        if (nv !== exp_v[64]) begin
          $display("Mismatch at %0t ns: nv expected %b, got %b", $time, exp_v[64], nv);
          errors++;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    int          start;
    logic [63:0] a;
    logic [63:0] b;
    errors  = 0;
    checks  = 0;
    ops_run = 0;
    rst_n   = 1'b0;
    req     = 1'b0;
    op      = FEQ;
    src0    = '0;
    src1    = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state and handshake with back-pressure
    start = errors;
    @(negedge clk);
    if (ack !== 1'b0 || result !== '0 || nv !== 1'b0) begin
      $display("Mismatch at %0t ns: ack/result/nv after reset expected 0/0/0, got %b/%h/%b",
               $time, ack, result, nv);
      errors++;
    end
    run_op(FLT, 64'h3FF0_0000_0000_0000, 64'h4000_0000_0000_0000, 5);
    run_op(FMAX, 64'hBFF0_0000_0000_0000, 64'h4008_0000_0000_0000, 5);
    run_op(FEQ, 64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 5);
    end_test("reset_handshake", start);

    // Ordered compares
    start = errors;
    for (int i = 0; i < RAND_ITER; i++) begin
      a = rand_operand();
      case (i % 4)
        0:       b = rand_operand();
        1:       b = a;
        2:       b = a ^ 64'h8000_0000_0000_0000;
        default: b = {a[63:52], 52'h0} | (rand_operand() & 64'h000F_FFFF_FFFF_FFFF);
      endcase
      run_op(FEQ, a, b, 0);
      run_op(FNE, a, b, 0);
      run_op(FLT, a, b, 0);
      run_op(FLE, a, b, 0);
    end
    end_test("ordered_compare", start);

    // Unordered forms and NaN signaling
    start = errors;
    for (int i = 0; i < N_NAN; i++) begin
      for (int j = 0; j < N_NAN; j++) begin
        for (int k = 0; k < N_NAN_OPS; k++) begin
          run_op(NAN_OPS[k], NAN_SET[i], NAN_SET[j], 0);
        end
      end
    end
    end_test("unordered_nan", start);

    // Max/min on random operands, both orders
    start = errors;
    for (int i = 0; i < RAND_ITER; i++) begin
      a = rand_operand();
      case (i % 3)
        0:       b = rand_operand();
        1:       b = a ^ 64'h8000_0000_0000_0000;
        default: b = (rand_operand() & 64'h800F_FFFF_FFFF_FFFF) | {1'b0, a[62:52], 52'h0};
      endcase
      run_op(FMAX, a, b, 0);
      run_op(FMIN, a, b, 0);
      run_op(FMAX, b, a, 0);
      run_op(FMIN, b, a, 0);
    end
    end_test("maxmin_random", start);

    // Zeros, single NaN and double NaN
    start = errors;
    for (int i = 0; i < N_SPEC; i++) begin
      for (int j = 0; j < N_SPEC; j++) begin
        run_op(FMAX, SPEC_SET[i], SPEC_SET[j], 0);
        run_op(FMIN, SPEC_SET[i], SPEC_SET[j], 0);
      end
    end
    end_test("maxmin_special", start);

    repeat (2) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("Error: %0d expected results were never checked", exp_q.size());
      errors++;
    end
    $display("Summary: 5 tests, %0d operations, %0d checks, %0d errors", ops_run, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fcmp_unit.f
+incdir+rtl
rtl/fcmp_pkg.sv
rtl/fcmp_classify.sv
rtl/fcmp_mag_cmp.sv
rtl/fcmp_cmp_max.sv
rtl/fcmp_result_stage.sv
rtl/fcmp_unit.sv
tb/fcmp_tb.sv

//--- Makefile
# Verilator build and run for the fcmp_unit testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := fcmp_tb
FILELIST  := fcmp_unit.f
MDIR      := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(MDIR) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation log reports success" || \
	  (echo "simulation log reports failure"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)
